// File: include/uart_tx_defines.svh
`ifndef UART_TX_DEFINES_SVH
`define UART_TX_DEFINES_SVH

// Number of independent transmit channels
`define UART_NUM_CHANNELS 4

// Bytes per channel FIFO as a power of two
`define UART_FIFO_DEPTH 8

// Clock cycles per serial bit in place of clk / baud
`define UART_CLKS_PER_BIT 16

// Width of the saturating dropped-write counter
`define UART_DROP_WIDTH 8

`endif

// File: verilog/uart_tx_pkg.sv
`include "uart_tx_defines.svh"
`default_nettype none

package uart_tx_pkg;

    // Channel index width is at least one bit
    localparam int CHAN_W = (`UART_NUM_CHANNELS > 1) ? $clog2(`UART_NUM_CHANNELS) : 1;

    typedef logic [7:0] byte_t;

    typedef logic [CHAN_W-1:0] chan_t;

    // One host write carrying a byte and its channel
    typedef struct packed {
        chan_t chan;
        byte_t data;
    } tx_req_t;

endpackage

`default_nettype wire

// File: verilog/sync_fifo.sv
`include "uart_tx_defines.svh"
`default_nettype none

module sync_fifo
    import uart_tx_pkg::*;
#(
    parameter int DEPTH = `UART_FIFO_DEPTH
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  push,
    input  wire byte_t push_data,
    input  wire logic  pop,
    output byte_t      rd_data,
    output logic       full,
    output logic       empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W:0] CNT_FULL = (PTR_W + 1)'(DEPTH);

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // Overflow never corrupts the buffer
    assign do_pop  = pop && !empty;

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    // Storage and read data register
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            rd_data <= mem[rd_ptr];  // Valid the cycle after pop
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == CNT_FULL);
            empty <= (count_next == '0);
        end
    end

    // Dispatcher must honour full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
        else $error("sync_fifo: push while full");

    // Engine must honour empty
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
        else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

// File: verilog/uart_tx_engine.sv
`include "uart_tx_defines.svh"
`default_nettype none

module uart_tx_engine
    import uart_tx_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  empty,
    input  wire byte_t rd_data,
    output logic       pop,
    output logic       serial,
    output logic       busy
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } state_t;

    state_t           state;
    state_t           state_next;
    logic [CNT_W-1:0] baud_cnt;
    logic             baud_tick;
    logic [2:0]       bit_cnt;
    byte_t            shift_q;
    logic             parity_q;
    logic             serial_next;

    // Counter only runs while a bit is on the line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
        end else if (state == S_IDLE || state == S_LOAD) begin
            baud_cnt <= '0;
        end else if (baud_tick) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign baud_tick = (baud_cnt == CNT_MAX);

    // Data bit index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (state != S_DATA) begin
            bit_cnt <= '0;
        end else if (baud_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Byte and its parity are captured in load
    always_ff @(posedge clk) begin
        if (state == S_LOAD) begin
            shift_q  <= rd_data;
            parity_q <= ^rd_data;  // Even parity
        end else if (state == S_DATA && baud_tick) begin
            shift_q <= {1'b0, shift_q[7:1]};  // LSB goes out first
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        case (state)
            S_IDLE: begin
                if (!empty) begin
                    pop        = 1'b1;  // rd_data ready in load
                    state_next = S_LOAD;
                end
            end
            S_LOAD: begin
                state_next = S_START;
            end
            S_START: begin
                if (baud_tick) begin
                    state_next = S_DATA;
                end
            end
            S_DATA: begin
                if (baud_tick && bit_cnt == 3'd7) begin
                    state_next = S_PARITY;
                end
            end
            S_PARITY: begin
                if (baud_tick) begin
                    state_next = S_STOP;
                end
            end
            S_STOP: begin
                if (baud_tick) begin
                    state_next = S_IDLE;
                end
            end
            default: begin
                state_next = S_IDLE;
            end
        endcase
    end

    // Line level for the current state
    always_comb begin
        case (state)
            S_START:  serial_next = 1'b0;
            S_DATA:   serial_next = shift_q[0];
            S_PARITY: serial_next = parity_q;
            default:  serial_next = 1'b1;  // Idle, load and stop
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            serial <= 1'b1;
        end else begin
            serial <= serial_next;
        end
    end

    assign busy = (state != S_IDLE);

    // The start bit goes out two edges after a pop from idle
    a_pop_idle: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !busy ##1 busy ##2 !serial)
        else $error("uart_tx_engine: pop outside idle or start bit late");

    // The serial register lags the state by one cycle but must already be high
    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> serial)
        else $error("uart_tx_engine: line low while not busy");

endmodule

`default_nettype wire

// File: verilog/tx_dispatch.sv
`include "uart_tx_defines.svh"
`default_nettype none

module tx_dispatch
    import uart_tx_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire tx_req_t                       req,
    input  wire logic                          req_valid,
    input  wire logic [`UART_NUM_CHANNELS-1:0] full,
    output logic                               req_ready,
    output logic [`UART_NUM_CHANNELS-1:0]      push,
    output byte_t                              push_data,
    output logic [`UART_DROP_WIDTH-1:0]        drop_count
);

    localparam int NUM_CH = `UART_NUM_CHANNELS;

    logic drop;

    // An unknown channel is never ready
    always_comb begin
        req_ready = 1'b0;
        push      = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (req.chan == chan_t'(i)) begin
                req_ready = !full[i];
                push[i]   = req_valid && !full[i];
            end
        end
    end

    assign push_data = req.data;  // Shared by all FIFOs
    assign drop      = req_valid && !req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;  // Saturates
        end
    end

    a_one_push: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(push))
        else $error("tx_dispatch: more than one push");

endmodule

`default_nettype wire

// File: verilog/uart_tx_hub.sv
`include "uart_tx_defines.svh"
`default_nettype none

module uart_tx_hub
    import uart_tx_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire tx_req_t                       req,
    input  wire logic                          req_valid,
    output wire logic                          req_ready,
    output wire logic [`UART_NUM_CHANNELS-1:0] serial,
    output wire logic [`UART_NUM_CHANNELS-1:0] busy,
    output wire logic [`UART_DROP_WIDTH-1:0]   drop_count
);

    logic [`UART_NUM_CHANNELS-1:0] push;
    logic [`UART_NUM_CHANNELS-1:0] full;
    byte_t                         push_data;

    tx_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .full       (full),
        .req_ready  (req_ready),
        .push       (push),
        .push_data  (push_data),
        .drop_count (drop_count)
    );

    // One FIFO and one transmitter per channel
    for (genvar i = 0; i < `UART_NUM_CHANNELS; i++) begin : g_chan
        logic  pop;
        logic  empty;
        byte_t rd_data;

        sync_fifo #(
            .DEPTH (`UART_FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[i]),
            .push_data (push_data),
            .pop       (pop),
            .rd_data   (rd_data),
            .full      (full[i]),
            .empty     (empty)
        );

        uart_tx_engine #(
            .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
        ) u_engine (
            .clk     (clk),
            .rst_n   (rst_n),
            .empty   (empty),
            .rd_data (rd_data),
            .pop     (pop),
            .serial  (serial[i]),  // Straight to the pin
            .busy    (busy[i])
        );
    end

endmodule

`default_nettype wire

// File: tests/uart_frame_monitor.sv
`include "uart_tx_defines.svh"
`default_nettype none

module uart_frame_monitor
    import uart_tx_pkg::*;
#(
    parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  serial,
    output logic       frame_valid,  // One-cycle pulse per decoded frame
    output byte_t      frame_data,
    output logic       frame_parity,
    output logic       frame_ok      // Start bit low and stop bit high
);
    timeunit 1ns;
    timeprecision 1ps;

    byte_t data;
    logic  start_low;
    logic  parity;
    logic  stop_high;

    initial begin
        frame_valid  <= 1'b0;
        frame_data   <= '0;
        frame_parity <= 1'b0;
        frame_ok     <= 1'b0;
        forever begin
            @(posedge clk);
            frame_valid <= 1'b0;
            // Line idles high, so the first low sample opens a frame
            if (rst_n && !serial) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);  // Middle of start bit
                start_low = !serial;
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(posedge clk);
                    data[i] = serial;  // LSB first
                end
                repeat (CLKS_PER_BIT) @(posedge clk);
                parity = serial;
                repeat (CLKS_PER_BIT) @(posedge clk);
                stop_high = serial;
                frame_data   <= data;
                frame_parity <= parity;
                frame_ok     <= start_low && stop_high;
                frame_valid  <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_uart_tx_hub.sv
`include "uart_tx_defines.svh"
`default_nettype none

module tb_uart_tx_hub
    import uart_tx_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CH       = `UART_NUM_CHANNELS;
    localparam int DEPTH        = `UART_FIFO_DEPTH;
    localparam int FRAME_CYCLES = 11 * `UART_CLKS_PER_BIT;
    localparam int LCG_WRITES   = 20;
    localparam int BP_CH        = NUM_CH / 2;
    localparam int BP_WRITES    = DEPTH + 2;
    localparam int DROP_WRITES  = 3;
    localparam int MAX_FRAMES   = 1 + LCG_WRITES + BP_WRITES + DROP_WRITES;
    // Worst case puts every frame on one channel
    localparam int WATCHDOG_CYCLES = MAX_FRAMES * (FRAME_CYCLES + 2) + 2 * FRAME_CYCLES + 1000;

    logic                        clk;
    logic                        rst_n;
    tx_req_t                     req;
    logic                        req_valid;
    logic                        req_ready;
    logic [NUM_CH-1:0]           serial;
    logic [NUM_CH-1:0]           busy;
    logic [`UART_DROP_WIDTH-1:0] drop_count;

    logic [NUM_CH-1:0] mon_valid;
    byte_t             mon_data [NUM_CH];
    logic [NUM_CH-1:0] mon_parity;
    logic [NUM_CH-1:0] mon_ok;

    byte_t       exp_q [NUM_CH][$];  // Accepted bytes per channel in write order
    string       test_name;
    int          frames_expected;
    int          frames_checked;
    int          drops_expected;
    int          peak_busy;
    logic [31:0] lcg;

    uart_tx_hub DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .serial     (serial),
        .busy       (busy),
        .drop_count (drop_count)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_mon
        uart_frame_monitor u_mon (
            .clk          (clk),
            .rst_n        (rst_n),
            .serial       (serial[i]),
            .frame_valid  (mon_valid[i]),
            .frame_data   (mon_data[i]),
            .frame_parity (mon_parity[i]),
            .frame_ok     (mon_ok[i])
        );
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Data plus parity carries an even number of ones
    function automatic logic even_parity(input byte_t b);
        logic p;
        p = 1'b0;
        for (int i = 0; i < 8; i++) begin
            p = p ^ b[i];
        end
        return p;
    endfunction

    function automatic int pending_frames();
        int total;
        total = 0;
        for (int i = 0; i < NUM_CH; i++) begin
            total += exp_q[i].size();
        end
        return total;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            abort_run($sformatf("Error %s: expected 0x%0h, actual 0x%0h",
                name, expected, actual));
        end
    endtask

    // Strobe stays high until the next write or end_strobe
    task automatic send_byte(input int ch, input byte_t data, output logic accepted);
        @(negedge clk);
        req.chan  = chan_t'(ch);
        req.data  = data;
        req_valid = 1'b1;
        #1;
        accepted = req_ready;  // Settled long before the rising edge
        if (accepted) begin
            exp_q[ch].push_back(data);
            frames_expected++;
        end else begin
            drops_expected++;
        end
    endtask

    task automatic end_strobe();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (pending_frames() != 0 || busy != '0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if ($countones(busy) > peak_busy) begin
            peak_busy <= $countones(busy);
        end
    end

    // Compare each decoded frame with the oldest accepted byte
    always @(posedge clk) begin
        byte_t exp_b;
        for (int i = 0; i < NUM_CH; i++) begin
            if (mon_valid[i]) begin
                if (exp_q[i].size() == 0) begin
                    abort_run($sformatf("Channel %0d sent a frame that was never accepted (%s)",
                        i, test_name));
                end else begin
                    exp_b = exp_q[i].pop_front();
                    expect_equal($sformatf("%s ch%0d data", test_name, i),
                        int'(exp_b), int'(mon_data[i]));
                    expect_equal($sformatf("%s ch%0d parity", test_name, i),
                        int'(even_parity(exp_b)), int'(mon_parity[i]));
                    expect_equal($sformatf("%s ch%0d framing", test_name, i), 1, int'(mon_ok[i]));
                    frames_checked++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("Timeout: test did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    initial begin
        logic  accepted;
        logic  saw_low;
        int    ch;
        int    fill [NUM_CH];
        byte_t data;

        req       = '0;
        req_valid = 1'b0;
        rst_n     = 1'b0;
        lcg       = 32'd86;
        test_name = "reset";
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        expect_equal("reset serial", (1 << NUM_CH) - 1, int'(serial));
        expect_equal("reset busy", 0, int'(busy));
        expect_equal("reset req_ready", 1, int'(req_ready));
        expect_equal("reset drop_count", 0, int'(drop_count));

        test_name = "single";
        send_byte(0, 8'hb4, accepted);
        end_strobe();
        expect_equal("single accept", 1, int'(accepted));
        wait_drain();

        // LCG writes keep every channel within its FIFO depth
        test_name = "independent";
        for (int c = 0; c < NUM_CH; c++) begin
            fill[c] = 0;
        end
        for (int n = 0; n < LCG_WRITES; n++) begin
            lcg = lcg_step(lcg);
            ch  = int'(lcg[23:16]) % NUM_CH;
            lcg = lcg_step(lcg);
            data = lcg[30:23];
            while (fill[ch] >= DEPTH) begin
                ch = (ch + 1) % NUM_CH;
            end
            send_byte(ch, data, accepted);
            expect_equal("independent accept", 1, int'(accepted));
            fill[ch]++;
        end
        end_strobe();
        wait_drain();
        expect_equal("independent overlap", 1, int'(peak_busy > 1));

        test_name = "backpressure";
        saw_low   = 1'b0;
        for (int n = 0; n < BP_WRITES; n++) begin
            lcg = lcg_step(lcg);
            send_byte(BP_CH, lcg[30:23], accepted);
            if (!accepted) begin
                saw_low = 1'b1;
            end
        end
        end_strobe();
        expect_equal("backpressure ready low", 1, int'(saw_low));
        for (int c = 0; c < NUM_CH; c++) begin
            @(negedge clk);
            req.chan = chan_t'(c);
            #1;
            expect_equal($sformatf("backpressure ready ch%0d", c), (c == BP_CH) ? 0 : 1,
                int'(req_ready));
        end
        expect_equal("backpressure drop_count", drops_expected, int'(drop_count));

        // The FIFO stays full until the current frame ends
        test_name = "drop";
        for (int n = 0; n < DROP_WRITES; n++) begin
            lcg = lcg_step(lcg);
            send_byte(BP_CH, lcg[30:23], accepted);
            end_strobe();
            expect_equal("drop accept", 0, int'(accepted));
            expect_equal("drop count", drops_expected, int'(drop_count));
        end
        wait_drain();

        test_name = "idle";
        repeat (2 * FRAME_CYCLES) begin
            @(negedge clk);
            expect_equal("idle serial", (1 << NUM_CH) - 1, int'(serial));
            expect_equal("idle busy", 0, int'(busy));
        end
        expect_equal("frames checked", frames_expected, frames_checked);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
verilog/uart_tx_pkg.sv
verilog/sync_fifo.sv
verilog/uart_tx_engine.sv
verilog/tx_dispatch.sv
verilog/uart_tx_hub.sv
tests/uart_frame_monitor.sv
tests/tb_uart_tx_hub.sv

// File: run.sh
#!/bin/sh
# Build and run the UART hub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module tb_uart_tx_hub -o sim_uart_tx_hub

status=0
output=$(./obj_dir/sim_uart_tx_hub 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx '>>> PASS'; then
    exit 0
fi
echo "Simulation did not report success (exit status $status)"
exit 1
